/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    //////////////////////////////////////////////////
    // Major opcodes the front end cares about
    //////////////////////////////////////////////////

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    typedef enum logic [1:0] {
        cls_other  = 2'd0,
        cls_branch = 2'd1,
        cls_jal    = 2'd2,
        cls_jalr   = 2'd3
    } insn_class_e;

    //////////////////////////////////////////////////
    // Field layouts of one 32-bit instruction word
    //////////////////////////////////////////////////

    // B-type, conditional branches
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    // J-type, JAL only
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // Opcode sits in the same bits in both views
    typedef union packed {
        b_type_t b_view;
        j_type_t j_view;
    } insn_word_u;

endpackage

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // One fetched word and the prediction made for it
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] insn;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_pkt_t;

    typedef struct packed {
        fetch_pkt_t              pkt;
        rv_isa_pkg::insn_class_e cls;
    } issue_pkt_t;

    // Outcome of a control instruction, from execute
    typedef struct packed {
        logic                    valid;
        rv_isa_pkg::insn_class_e cls;
        logic                    taken;
        logic [31:0]             pc_exec;
        logic [31:0]             rs1;
        logic [31:0]             imm;
    } resolve_t;

    //////////////////////////////////////////////////
    // Wishbone classic, read only
    //////////////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* logic/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int btb_entries = 16
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic [31:0] lookup_pc,
    output logic        hit,
    output logic [31:0] target,
    input  logic        update_valid,
    input  logic [31:0] update_pc,
    input  logic [31:0] update_target,
    input  logic        update_taken
);

    localparam int idx_w = $clog2(btb_entries);
    localparam int tag_w = 30 - idx_w;

    logic [btb_entries-1:0] valid_q;
    logic [tag_w-1:0]       tag_mem    [btb_entries];
    logic [31:0]            target_mem [btb_entries];
    logic                   taken_mem  [btb_entries];

    logic [idx_w-1:0] lookup_idx;
    logic [idx_w-1:0] update_idx;

    // Word address low bits pick the entry
    assign lookup_idx = lookup_pc[idx_w+1:2];
    assign update_idx = update_pc[idx_w+1:2];

    // Only a tagged entry with its taken bit set redirects fetch
    assign hit    = valid_q[lookup_idx] && taken_mem[lookup_idx]
                    && (tag_mem[lookup_idx] == lookup_pc[31:idx_w+2]);
    assign target = target_mem[lookup_idx];

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else if (update_valid)
        begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // A not-taken outcome rewrites the entry with taken cleared
    always_ff @(posedge CLK)
    begin
        if (update_valid)
        begin
            tag_mem[update_idx]    <= update_pc[31:idx_w+2];
            target_mem[update_idx] <= update_target;
            taken_mem[update_idx]  <= update_taken;
        end
    end

endmodule

/* logic/pc_stage.sv */
`timescale 1ns/1ps

module pc_stage #(
    parameter logic [31:0] reset_pc    = 32'h0000_0000,
    parameter int          btb_entries = 16
) (
    input  logic                CLK,
    input  logic                rst_n,
    input  fetch_pkg::resolve_t resolve,
    input  logic [31:0]         next_pc_seen,
    input  logic                early_redirect,
    input  logic [31:0]         early_target,
    input  logic                fetch_take,
    output logic [31:0]         fetch_pc,
    output logic                pred_taken,
    output logic [31:0]         pred_target,
    output logic                flush
);

    logic [31:0] pc_q;
    logic        flush_q;

    logic        btb_hit;
    logic [31:0] btb_target;
    logic [31:0] pc_plus_4;

    logic [31:0] jump_base;
    logic [31:0] jump_target;
    logic        redirect_taken;
    logic [31:0] real_next;
    logic        mismatch;

    branch_target_buffer #(
        .btb_entries (btb_entries)
    ) i_btb (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .lookup_pc     (pc_q),
        .hit           (btb_hit),
        .target        (btb_target),
        .update_valid  (resolve.valid),
        .update_pc     (resolve.pc_exec),
        .update_target (jump_target),
        .update_taken  (redirect_taken)
    );

    //////////////////////////////////////////////////
    // Resolution check
    //////////////////////////////////////////////////

    always_comb
    begin
        // jalr adds to rs1, jal and branches add to their own pc
        if (resolve.cls == rv_isa_pkg::cls_jalr)
        begin
            jump_base = resolve.rs1;
        end
        else
        begin
            jump_base = resolve.pc_exec;
        end
        jump_target = jump_base + resolve.imm;

        redirect_taken = (resolve.cls == rv_isa_pkg::cls_jal)
                         || (resolve.cls == rv_isa_pkg::cls_jalr)
                         || ((resolve.cls == rv_isa_pkg::cls_branch) && resolve.taken);

        real_next = redirect_taken ? jump_target : resolve.pc_exec + 32'd4;
        mismatch  = resolve.valid && (real_next != next_pc_seen);
    end

    //////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////

    assign pc_plus_4 = pc_q + 32'd4;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q    <= reset_pc;
            flush_q <= 1'b0;
        end
        else
        begin
            flush_q <= mismatch;
            if (mismatch)
            begin
                pc_q <= real_next;
            end
            // A wrong-path JAL may redirect in the same cycle as a flush
            else if (early_redirect && !flush_q)
            begin
                pc_q <= early_target;
            end
            else if (fetch_take)
            begin
                pc_q <= pred_target;
            end
        end
    end

    assign fetch_pc    = pc_q;
    assign pred_taken  = btb_hit;
    assign pred_target = btb_hit ? btb_target : pc_plus_4;
    assign flush       = flush_q;

endmodule

/* logic/wb_fetch_master.sv */
`timescale 1ns/1ps

module wb_fetch_master (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic [31:0]           fetch_pc,
    input  logic                  pred_taken,
    input  logic [31:0]           pred_target,
    output logic                  fetch_take,
    input  logic                  discard,
    output fetch_pkg::wb_req_t    wb_req,
    input  fetch_pkg::wb_rsp_t    wb_rsp,
    output logic                  push,
    output fetch_pkg::fetch_pkt_t push_pkt,
    input  logic                  space
);

    typedef enum logic {
        st_idle = 1'b0,
        st_bus  = 1'b1
    } state_e;

    state_e      state_q;
    logic        stale_q;
    logic [31:0] pc_q;
    logic        pred_taken_q;
    logic [31:0] pred_target_q;

    // No new request while the front end is being redirected
    assign fetch_take = (state_q == st_idle) && space && !discard;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= st_idle;
            stale_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                st_idle:
                begin
                    if (fetch_take)
                    begin
                        state_q <= st_bus;
                        stale_q <= 1'b0;
                    end
                end
                st_bus:
                begin
                    // Hold the cycle to ack, remember that the word is dead
                    if (wb_rsp.ack)
                    begin
                        state_q <= st_idle;
                    end
                    if (discard)
                    begin
                        stale_q <= 1'b1;
                    end
                end
                default:
                begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fetch_take)
        begin
            pc_q          <= {fetch_pc[31:2], 2'b00};
            pred_taken_q  <= pred_taken;
            pred_target_q <= pred_target;
        end
    end

    always_comb
    begin
        wb_req.cyc = (state_q == st_bus);
        wb_req.stb = (state_q == st_bus);
        wb_req.adr = pc_q;

        push                 = (state_q == st_bus) && wb_rsp.ack && !stale_q && !discard;
        push_pkt.pc          = pc_q;
        push_pkt.insn        = wb_rsp.dat;
        push_pkt.pred_taken  = pred_taken_q;
        push_pkt.pred_target = pred_target_q;
    end

endmodule

/* logic/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue #(
    parameter int queue_depth = 4
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  push,
    input  fetch_pkg::fetch_pkt_t push_pkt,
    input  logic                  pop,
    output fetch_pkg::fetch_pkt_t head,
    output logic                  empty,
    output logic                  space
);

    localparam int              ptr_w       = $clog2(queue_depth);
    localparam logic [ptr_w:0]  depth_count = queue_depth[ptr_w:0];

    fetch_pkg::fetch_pkt_t mem [queue_depth];

    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w:0]   count_q;

    assign head  = mem[rd_ptr_q];
    assign empty = (count_q == '0);
    // The master only asks while idle, so one free slot covers its request
    assign space = (count_q < depth_count);

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (flush)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            mem[wr_ptr_q] <= push_pkt;
        end
    end

endmodule

/* logic/insn_predecoder.sv */
`timescale 1ns/1ps

module insn_predecoder (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  flush,
    input  fetch_pkg::fetch_pkt_t head,
    input  logic                  empty,
    output logic                  pop,
    output logic                  issue_valid,
    output fetch_pkg::issue_pkt_t issue,
    input  logic                  issue_ready,
    output logic                  early_redirect,
    output logic [31:0]           early_target
);

    rv_isa_pkg::insn_word_u  word;
    rv_isa_pkg::insn_class_e cls;
    logic [31:0]             j_imm;
    logic [31:0]             jal_target;
    logic                    jal_fix;
    logic                    load;

    logic                    valid_q;
    fetch_pkg::issue_pkt_t   issue_q;
    logic                    redirect_q;
    logic [31:0]             redirect_target_q;

    assign word = head.insn;

    //////////////////////////////////////////////////
    // Classify the head word
    //////////////////////////////////////////////////

    always_comb
    begin
        case (word.j_view.opcode)
            rv_isa_pkg::op_jal:  cls = rv_isa_pkg::cls_jal;
            rv_isa_pkg::op_jalr: cls = rv_isa_pkg::cls_jalr;
            rv_isa_pkg::op_branch:
            begin
                // funct3 010 and 011 are not branches
                if (word.b_view.funct3[2:1] == 2'b01)
                begin
                    cls = rv_isa_pkg::cls_other;
                end
                else
                begin
                    cls = rv_isa_pkg::cls_branch;
                end
            end
            default: cls = rv_isa_pkg::cls_other;
        endcase
    end

    assign j_imm = {{12{word.j_view.imm_20}}, word.j_view.imm_19_12,
                    word.j_view.imm_11, word.j_view.imm_10_1, 1'b0};
    assign jal_target = head.pc + j_imm;
    assign jal_fix    = (cls == rv_isa_pkg::cls_jal) && (head.pred_target != jal_target);

    // Slot refills when free or draining, never during a redirect
    assign load = !empty && !flush && !redirect_q && (!valid_q || issue_ready);
    assign pop  = load;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q    <= 1'b0;
            redirect_q <= 1'b0;
        end
        else
        begin
            redirect_q <= load && jal_fix;
            if (flush)
            begin
                valid_q <= 1'b0;
            end
            else if (load)
            begin
                valid_q <= 1'b1;
            end
            else if (issue_ready)
            begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (load)
        begin
            issue_q.pkt       <= head;
            issue_q.cls       <= cls;
            redirect_target_q <= jal_target;
            // JAL leaves with the target it really jumps to
            if (cls == rv_isa_pkg::cls_jal)
            begin
                issue_q.pkt.pred_taken  <= 1'b1;
                issue_q.pkt.pred_target <= jal_target;
            end
        end
    end

    assign issue_valid    = valid_q && !flush;
    assign issue          = issue_q;
    assign early_redirect = redirect_q;
    assign early_target   = redirect_target_q;

endmodule

/* logic/front_end_top.sv */
`timescale 1ns/1ps

module front_end_top #(
    parameter logic [31:0] reset_pc    = 32'h0000_0000,
    parameter int          btb_entries = 16,
    parameter int          queue_depth = 4
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    output fetch_pkg::wb_req_t    wb_req,
    input  fetch_pkg::wb_rsp_t    wb_rsp,
    output logic                  issue_valid,
    output fetch_pkg::issue_pkt_t issue,
    input  logic                  issue_ready,
    input  fetch_pkg::resolve_t   resolve,
    input  logic [31:0]           next_pc_seen,
    output logic                  flush
);

    logic [31:0]           fetch_pc;
    logic                  pred_taken;
    logic [31:0]           pred_target;
    logic                  fetch_take;
    logic                  early_redirect;
    logic [31:0]           early_target;
    logic                  discard;
    logic                  push;
    fetch_pkg::fetch_pkt_t push_pkt;
    logic                  pop;
    fetch_pkg::fetch_pkt_t head;
    logic                  empty;
    logic                  space;

    // Either redirect kills everything fetched on the old path
    assign discard = flush || early_redirect;

    pc_stage #(
        .reset_pc    (reset_pc),
        .btb_entries (btb_entries)
    ) i_pc_stage (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .resolve        (resolve),
        .next_pc_seen   (next_pc_seen),
        .early_redirect (early_redirect),
        .early_target   (early_target),
        .fetch_take     (fetch_take),
        .fetch_pc       (fetch_pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .flush          (flush)
    );

    wb_fetch_master i_fetch_master (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .fetch_take  (fetch_take),
        .discard     (discard),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .push        (push),
        .push_pkt    (push_pkt),
        .space       (space)
    );

    fetch_queue #(
        .queue_depth (queue_depth)
    ) i_fetch_queue (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (discard),
        .push     (push),
        .push_pkt (push_pkt),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .space    (space)
    );

    insn_predecoder i_predecoder (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .flush          (flush),
        .head           (head),
        .empty          (empty),
        .pop            (pop),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .early_redirect (early_redirect),
        .early_target   (early_target)
    );

endmodule

/* testbench/tb_front_end.sv */
`timescale 1ns/1ps

module tb_front_end;

    localparam logic [31:0] reset_pc    = 32'h0000_0040;
    localparam int          btb_entries = 16;
    localparam int          queue_depth = 4;
    localparam int          mem_words   = 256;
    localparam int          n_issues    = 400;
    localparam int          clk_period  = 10;
    // Slowest fetch plus redirect penalty, per issued word
    localparam int          worst_cycles_per_issue = 12;
    localparam int          timeout_margin         = 4;

    logic                  CLK;
    logic                  rst_n;
    fetch_pkg::wb_req_t    wb_req;
    fetch_pkg::wb_rsp_t    wb_rsp;
    logic                  issue_valid;
    fetch_pkg::issue_pkt_t issue;
    logic                  issue_ready;
    fetch_pkg::resolve_t   resolve;
    logic [31:0]           next_pc_seen;
    logic                  flush;

    logic [31:0] mem [mem_words];
    logic [31:0] rand_state;
    int          error_count;
    int          issued_count;
    int          resolve_count;
    int          flush_count;

    // Memory side of the bus
    logic        bus_open;
    logic [31:0] bus_adr;
    logic [1:0]  wait_left;

    // Backend and reference model state
    logic [31:0]         expect_pc;
    logic                pending;
    logic [31:0]         pend_pc;
    logic [31:0]         pend_word;
    logic                want_resolve;
    logic                res_active;
    logic                exp_flush;
    fetch_pkg::resolve_t res_next;
    logic [31:0]         seen_next;

    // Direct-mapped predictor model
    logic        btb_valid  [btb_entries];
    logic [31:0] btb_tag    [btb_entries];
    logic [31:0] btb_target [btb_entries];
    logic        btb_taken  [btb_entries];

    front_end_top #(
        .reset_pc    (reset_pc),
        .btb_entries (btb_entries),
        .queue_depth (queue_depth)
    ) i_dut (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .resolve      (resolve),
        .next_pc_seen (next_pc_seen),
        .flush        (flush)
    );

    always #5 CLK = ~CLK;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        error_count++;
    endtask

    function automatic logic [31:0] j_imm_of(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] b_imm_of(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, rv_isa_pkg::op_jal};
    endfunction

    function automatic logic [31:0] branch_word(input logic [31:0] off,
                                                input logic [2:0] funct3);
        return {off[12], off[10:5], 5'd2, 5'd1, funct3, off[4:1], off[11],
                rv_isa_pkg::op_branch};
    endfunction

    function automatic rv_isa_pkg::insn_class_e class_of(input logic [31:0] w);
        if (w[6:0] == rv_isa_pkg::op_jal)
        begin
            return rv_isa_pkg::cls_jal;
        end
        if (w[6:0] == rv_isa_pkg::op_jalr)
        begin
            return rv_isa_pkg::cls_jalr;
        end
        // funct3 010 and 011 are unused in the branch group
        if ((w[6:0] == rv_isa_pkg::op_branch) && (w[14:13] != 2'b01))
        begin
            return rv_isa_pkg::cls_branch;
        end
        return rv_isa_pkg::cls_other;
    endfunction

    function automatic logic [6:0] filler_opcode(input logic [2:0] pick);
        case (pick)
            3'd0, 3'd5: return 7'b0010011;
            3'd1, 3'd6: return 7'b0110011;
            3'd2, 3'd7: return 7'b0000011;
            3'd3:       return 7'b0100011;
            default:    return 7'b0110111;
        endcase
    endfunction

    function automatic int btb_index(input logic [31:0] pc);
        return int'((pc >> 2) % btb_entries);
    endfunction

    function automatic logic btb_hit_of(input logic [31:0] pc);
        int idx;
        idx = btb_index(pc);
        return btb_valid[idx] && btb_taken[idx] && (btb_tag[idx] == pc);
    endfunction

    function automatic logic [31:0] predicted_next(input logic [31:0] pc,
                                                   input logic [31:0] w);
        int idx;
        idx = btb_index(pc);
        // A JAL always continues at its target, by BTB or by early redirect
        if (class_of(w) == rv_isa_pkg::cls_jal)
        begin
            return pc + j_imm_of(w);
        end
        if (btb_hit_of(pc))
        begin
            return btb_target[idx];
        end
        return pc + 32'd4;
    endfunction

    //////////////////////////////////////////////////
    // Program image
    //////////////////////////////////////////////////

    task automatic load_program();
        logic [31:0] r;
        logic [31:0] s;
        for (int i = 0; i < mem_words; i++)
        begin
            r = lcg_next();
            s = lcg_next();
            mem[i] = {r[31:7], filler_opcode(s[31:29])};
        end
        // Backward loop branch, forward JAL, forward branch, closing JAL
        mem[32'h0a0 >> 2] = branch_word(32'h040 - 32'h0a0, 3'b000);
        mem[32'h0c8 >> 2] = jal_word(32'h120 - 32'h0c8);
        mem[32'h140 >> 2] = branch_word(32'h180 - 32'h140, 3'b101);
        mem[32'h1c4 >> 2] = jal_word(32'h040 - 32'h1c4);
    endtask

    task automatic check_reset_state();
        if (issue_valid !== 1'b0)
        begin
            value_error("issue_valid", {31'd0, issue_valid}, 32'd0);
        end
        if (flush !== 1'b0)
        begin
            value_error("flush", {31'd0, flush}, 32'd0);
        end
        if (wb_req.cyc !== 1'b0)
        begin
            value_error("wb_req.cyc", {31'd0, wb_req.cyc}, 32'd0);
        end
        if (wb_req.stb !== 1'b0)
        begin
            value_error("wb_req.stb", {31'd0, wb_req.stb}, 32'd0);
        end
    endtask

    //////////////////////////////////////////////////
    // Wishbone memory, one step per falling edge
    //////////////////////////////////////////////////

    task automatic bus_step();
        logic [31:0] r;
        if (wb_rsp.ack)
        begin
            wb_rsp.ack = 1'b0;
            if (wb_req.cyc || wb_req.stb)
            begin
                $display("Bus cycle still open in the cycle after ack at %0t", $time);
                error_count++;
            end
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            if (!bus_open)
            begin
                bus_open  = 1'b1;
                bus_adr   = wb_req.adr;
                r         = lcg_next();
                wait_left = r[31:30];
                if (wb_req.adr[1:0] !== 2'b00)
                begin
                    value_error("wb_req.adr", wb_req.adr, {wb_req.adr[31:2], 2'b00});
                end
            end
            else if (wb_req.adr !== bus_adr)
            begin
                value_error("wb_req.adr", wb_req.adr, bus_adr);
            end
            if (wait_left == 2'd0)
            begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem[bus_adr[9:2]];
                bus_open   = 1'b0;
            end
            else
            begin
                wait_left = wait_left - 2'd1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Backend model
    //////////////////////////////////////////////////

    task automatic resolve_pending(input logic [31:0] seen, output logic [31:0] real_next);
        logic        taken;
        logic [31:0] imm;
        logic [31:0] r;
        int          idx;
        r = lcg_next();
        if (class_of(pend_word) == rv_isa_pkg::cls_jal)
        begin
            imm   = j_imm_of(pend_word);
            taken = 1'b1;
        end
        else
        begin
            imm   = b_imm_of(pend_word);
            taken = r[31];
        end
        real_next = taken ? pend_pc + imm : pend_pc + 32'd4;

        res_next.valid   = 1'b1;
        res_next.cls     = class_of(pend_word);
        res_next.taken   = taken;
        res_next.pc_exec = pend_pc;
        res_next.rs1     = lcg_next();
        res_next.imm     = imm;
        seen_next        = seen;
        exp_flush        = (real_next != seen);
        want_resolve     = 1'b1;
        resolve_count++;
        if (exp_flush)
        begin
            flush_count++;
        end

        idx             = btb_index(pend_pc);
        btb_valid[idx]  = 1'b1;
        btb_tag[idx]    = pend_pc;
        btb_target[idx] = pend_pc + imm;
        btb_taken[idx]  = taken;
    endtask

    task automatic take_issue(input fetch_pkg::issue_pkt_t p);
        logic [31:0]             w;
        logic [31:0]             real_next;
        logic [31:0]             exp_target;
        logic                    exp_taken;
        rv_isa_pkg::insn_class_e cls;
        logic                    wrong_path;
        w          = mem[p.pkt.pc[9:2]];
        cls        = class_of(w);
        wrong_path = 1'b0;
        // Prediction as the predictor stood when this word was fetched
        exp_taken  = (cls == rv_isa_pkg::cls_jal) || btb_hit_of(p.pkt.pc);
        exp_target = predicted_next(p.pkt.pc, w);
        issued_count++;
        if (p.pkt.pc !== expect_pc)
        begin
            value_error("issue.pkt.pc", p.pkt.pc, expect_pc);
        end
        if (p.pkt.insn !== w)
        begin
            value_error("issue.pkt.insn", p.pkt.insn, w);
        end
        if (p.cls !== cls)
        begin
            value_error("issue.cls", {30'd0, p.cls}, {30'd0, cls});
        end
        if (p.pkt.pred_taken !== exp_taken)
        begin
            value_error("issue.pkt.pred_taken", {31'd0, p.pkt.pred_taken},
                        {31'd0, exp_taken});
        end
        if (p.pkt.pred_target !== exp_target)
        begin
            value_error("issue.pkt.pred_target", p.pkt.pred_target, exp_target);
        end

        // This word is what followed the pending control instruction
        if (pending)
        begin
            pending = 1'b0;
            resolve_pending(p.pkt.pc, real_next);
            if (real_next != p.pkt.pc)
            begin
                wrong_path = 1'b1;
                expect_pc  = real_next;
            end
        end

        if (!wrong_path)
        begin
            if (cls == rv_isa_pkg::cls_other)
            begin
                expect_pc = p.pkt.pc + 32'd4;
            end
            else
            begin
                pending   = 1'b1;
                pend_pc   = p.pkt.pc;
                pend_word = w;
                expect_pc = exp_target;
            end
        end
    endtask

    task automatic backend_step();
        logic        flush_now;
        logic        hold;
        logic [31:0] r;
        flush_now = 1'b0;
        hold      = 1'b0;
        if (res_active)
        begin
            flush_now    = exp_flush;
            res_active   = 1'b0;
            resolve      = '0;
            next_pc_seen = '0;
            hold         = 1'b1;
        end
        // flush is high only in the cycle right after a mismatching resolution
        if (flush !== flush_now)
        begin
            value_error("flush", {31'd0, flush}, {31'd0, flush_now});
        end

        if (want_resolve)
        begin
            resolve      = res_next;
            next_pc_seen = seen_next;
            want_resolve = 1'b0;
            res_active   = 1'b1;
            issue_ready  = 1'b0;
        end
        else if (hold)
        begin
            issue_ready = 1'b0;
        end
        else
        begin
            r           = lcg_next();
            issue_ready = (r[31:30] != 2'b00);
            if (issue_valid && issue_ready)
            begin
                take_issue(issue);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        CLK             = 1'b0;
        rst_n           = 1'b0;
        wb_rsp          = '0;
        issue_ready     = 1'b0;
        resolve         = '0;
        next_pc_seen    = '0;
        rand_state      = 32'h30a4db89;
        error_count     = 0;
        issued_count    = 0;
        resolve_count   = 0;
        flush_count     = 0;
        bus_open        = 1'b0;
        bus_adr         = '0;
        wait_left       = '0;
        expect_pc       = reset_pc;
        pending         = 1'b0;
        pend_pc         = '0;
        pend_word       = '0;
        want_resolve    = 1'b0;
        res_active      = 1'b0;
        exp_flush       = 1'b0;
        res_next        = '0;
        seen_next       = '0;
        for (int i = 0; i < btb_entries; i++)
        begin
            btb_valid[i]  = 1'b0;
            btb_tag[i]    = '0;
            btb_target[i] = '0;
            btb_taken[i]  = 1'b0;
        end
        load_program();

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        check_reset_state();
        rst_n = 1'b1;

        while (issued_count < n_issues)
        begin
            @(negedge CLK);
            bus_step();
            backend_step();
        end

        $display("Summary: %0d errors, %0d issues, %0d resolutions, %0d flushes",
                 error_count, issued_count, resolve_count, flush_count);
        if (error_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial
    begin
        #(n_issues * worst_cycles_per_issue * timeout_margin * clk_period);
        $display("Timeout: only %0d of %0d issues seen", issued_count, n_issues);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/branch_target_buffer.sv
logic/pc_stage.sv
logic/wb_fetch_master.sv
logic/fetch_queue.sv
logic/insn_predecoder.sv
logic/front_end_top.sv
testbench/tb_front_end.sv

/* Makefile */
TOP := tb_front_end

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): build.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only -Wall --top-module front_end_top \
		logic/rv_isa_pkg.sv logic/fetch_pkg.sv logic/branch_target_buffer.sv \
		logic/pc_stage.sv logic/wb_fetch_master.sv logic/fetch_queue.sv \
		logic/insn_predecoder.sv logic/front_end_top.sv

clean:
	rm -rf obj_dir sim.log
